// ==== source/cart_pkg.sv ====
package cart_pkg;

    // Mapper selection carried by the cartridge descriptor
    typedef enum logic [3:0] {
        MAPPER_NONE        = 4'd0,
        MAPPER_ASCII16     = 4'd1,
        MAPPER_RTYPE       = 4'd2,
        MAPPER_MSXWRITE    = 4'd3,
        MAPPER_SUPERSWANGI = 4'd4,
        MAPPER_KONAMI      = 4'd5
    } mapper_typ_t;

    // Cartridge memory address covers ROM and save RAM
    localparam int MEM_ADDR_W  = 27;
    // ROM size is given in bytes
    localparam int ROM_SIZE_W  = 25;
    // SRAM size is given in kilobytes
    localparam int SRAM_SIZE_W = 16;

    // Save RAM storage inside the slot
    localparam int SRAM_DEPTH  = 8192;
    localparam int SRAM_ADDR_W = $clog2(SRAM_DEPTH);

    // Each cartridge id keeps its own bank registers
    localparam int NUM_IDS = 2;
    localparam int ID_W    = $clog2(NUM_IDS);

    // Bank value that maps save RAM into an ASCII16 page
    localparam logic [7:0] SRAM_BANK_CODE = 8'h10;
    // Address shown by a mapper that does not own the cycle
    localparam logic [MEM_ADDR_W-1:0] ADDR_IDLE = '1;
    // Above this size the save RAM decodes 13 address bits instead of 11
    localparam logic [SRAM_SIZE_W-1:0] SRAM_SMALL_KB = 16'd2;

    // ASCII16 family constants
    localparam logic [7:0]  A16_BANK_RST      = 8'h00;
    localparam logic [7:0]  RTYPE_FIXED_BANK  = 8'h0F;
    localparam logic [7:0]  RTYPE_MASK_HI     = 8'h17;
    localparam logic [7:0]  RTYPE_MASK_LO     = 8'h1F;
    localparam logic [15:0] MSXW_ALT_ADDR_LO  = 16'h6FFF;
    localparam logic [15:0] MSXW_ALT_ADDR_HI  = 16'h7FFF;
    localparam logic [15:0] SWANGI_BANK_ADDR  = 16'h8000;

    // Konami has four 8 KB pages, the first one fixed
    localparam int         KONAMI_BANKS      = 4;
    localparam logic [7:0] KONAMI_FIXED_BANK = 8'h00;

    // Mask for a ROM with count banks, a zero count stands for all 256
    function automatic logic [7:0] block_mask(input logic [7:0] count);
        return (count == 8'd0) ? 8'hFF : count - 8'd1;
    endfunction

    // Bank numbers below the bank count pass unchanged, larger ones wrap by the mask
    function automatic logic [7:0] bank_reduce(input logic [7:0] value,
                                               input logic [7:0] count);
        if (count == 8'd0 || value < count) begin
            return value;
        end
        return value & block_mask(count);
    endfunction

endpackage

// ==== source/mapper_ascii16.sv ====
`timescale 1ns/1ps

module mapper_ascii16 (
    input  logic                             cpu_bus,
    input  logic                             rst,
    input  logic [15:0]                      addr,
    input  logic [7:0]                       data_in,
    input  logic                             mreq,
    input  logic                             req,
    input  logic                             rd,
    input  logic                             wr,
    input  cart_pkg::mapper_typ_t            typ,
    input  logic [cart_pkg::ID_W-1:0]        block_id,
    input  logic [cart_pkg::ROM_SIZE_W-1:0]  rom_size,
    input  logic [cart_pkg::SRAM_SIZE_W-1:0] sram_size,
    output logic                             ram_cs,
    output logic                             sram_cs,
    output logic                             rnw,
    output logic [cart_pkg::MEM_ADDR_W-1:0]  mem_addr
);

    import cart_pkg::*;

    logic                  family;
    logic                  mapped;
    logic                  cs;
    logic                  sram_exists;
    logic [7:0]            nr_blocks;
    logic [7:0]            plain_bank;
    logic                  match_wr;
    logic                  bank_sel;
    logic [7:0]            bank_data;
    logic                  sram_code;
    logic [7:0]            bank_base;
    logic                  bank_wr;
    logic [7:0]            bank_q    [NUM_IDS][2];
    logic                  sram_en_q [NUM_IDS][2];
    logic                  sram_en;
    logic [MEM_ADDR_W-1:0] rom_addr;
    logic [MEM_ADDR_W-1:0] sram_addr;
    logic                  rom_hit;

    // The four variants share one datapath and differ only in write decode
    assign family = typ inside {MAPPER_ASCII16, MAPPER_RTYPE, MAPPER_MSXWRITE,
                                MAPPER_SUPERSWANGI};
    // Only the two middle pages 4000-BFFF belong to the cartridge
    assign mapped = addr[15] ^ addr[14];
    assign cs     = family && mapped && mreq;

    assign sram_exists = (sram_size != '0);
    // Number of 16 KB banks in the ROM image
    assign nr_blocks  = rom_size[21:14];
    assign plain_bank = bank_reduce(data_in, nr_blocks);

    // Per-variant write window, bank value and page lookup
    always_comb begin
        match_wr  = 1'b0;
        bank_sel  = addr[12];
        bank_data = plain_bank;
        sram_code = 1'b0;
        bank_base = bank_q[block_id][addr[15]];
        case (typ)
            MAPPER_ASCII16: begin
                // 6000-67FF feeds the lower page and 7000-77FF the upper page
                match_wr  = (addr[15:11] == 5'b01100) || (addr[15:11] == 5'b01110);
                sram_code = (data_in == SRAM_BANK_CODE) && sram_exists;
            end
            MAPPER_RTYPE: begin
                // Only the upper page switches, the lower page stays at bank 0Fh
                match_wr  = (addr[15:12] == 4'b0111);
                bank_sel  = 1'b1;
                bank_data = data_in & (data_in[4] ? RTYPE_MASK_HI : RTYPE_MASK_LO);
                bank_base = addr[15] ? bank_q[block_id][1] : RTYPE_FIXED_BANK;
            end
            MAPPER_MSXWRITE: begin
                // Same windows as ASCII16 plus the two mirrors used by the game
                match_wr = (addr[15:11] == 5'b01100) || (addr[15:11] == 5'b01110)
                        || (addr == MSXW_ALT_ADDR_LO) || (addr == MSXW_ALT_ADDR_HI);
            end
            MAPPER_SUPERSWANGI: begin
                // A single register at 8000 holds twice the bank number
                match_wr  = (addr == SWANGI_BANK_ADDR);
                bank_sel  = 1'b1;
                bank_data = bank_reduce({1'b0, data_in[7:1]}, nr_blocks);
            end
            default: begin
                match_wr = 1'b0;
            end
        endcase
    end

    // A bank register is written once per CPU write cycle, on the req pulse
    assign bank_wr = cs && wr && req && match_wr;

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                for (int j = 0; j < 2; j++) begin
                    bank_q[i][j]    <= A16_BANK_RST;
                    sram_en_q[i][j] <= 1'b0;
                end
            end
        end else if (bank_wr) begin
            // The SRAM code maps save RAM and leaves the ROM bank untouched
            sram_en_q[block_id][bank_sel] <= sram_code;
            if (!sram_code) begin
                bank_q[block_id][bank_sel] <= bank_data;
            end
        end
    end

    // Save RAM only exists on plain ASCII16 cartridges that declare some
    assign sram_en = sram_en_q[block_id][addr[15]] && (typ == MAPPER_ASCII16) && sram_exists;

    // Small save RAMs mirror every 2 KB
    assign sram_addr = (sram_size > SRAM_SMALL_KB) ? MEM_ADDR_W'(addr[12:0])
                                                   : MEM_ADDR_W'(addr[10:0]);

    assign rom_addr = MEM_ADDR_W'({bank_base, addr[13:0]});
    // Reads beyond the end of the image see no ROM
    assign rom_hit  = (rom_addr < MEM_ADDR_W'(rom_size));

    assign sram_cs  = cs && sram_en && (rd || wr);
    assign ram_cs   = cs && rom_hit && !sram_en && rd;
    // Save RAM writes are only accepted in the upper page
    assign rnw      = !(sram_cs && wr && addr[15]);
    assign mem_addr = cs ? (sram_en ? sram_addr : rom_addr) : ADDR_IDLE;

    // ROM and save RAM share the memory address and must never both be selected
    assert property (@(posedge cpu_bus) disable iff (rst) !(ram_cs && sram_cs))
        else $error("mapper_ascii16 selects ROM and SRAM together");

    // An idle mapper must stay neutral for the merge in cart_sram
    assert property (@(posedge cpu_bus) disable iff (rst)
        !cs |-> (mem_addr == ADDR_IDLE && !ram_cs && !sram_cs && rnw))
        else $error("mapper_ascii16 drives the bus while not selected");

endmodule

// ==== source/mapper_konami.sv ====
`timescale 1ns/1ps

module mapper_konami (
    input  logic                             cpu_bus,
    input  logic                             rst,
    input  logic [15:0]                      addr,
    input  logic [7:0]                       data_in,
    input  logic                             mreq,
    input  logic                             req,
    input  logic                             rd,
    input  logic                             wr,
    input  cart_pkg::mapper_typ_t            typ,
    input  logic [cart_pkg::ID_W-1:0]        block_id,
    input  logic [cart_pkg::ROM_SIZE_W-1:0]  rom_size,
    input  logic [cart_pkg::SRAM_SIZE_W-1:0] sram_size,
    output logic                             ram_cs,
    output logic                             sram_cs,
    output logic                             rnw,
    output logic [cart_pkg::MEM_ADDR_W-1:0]  mem_addr
);

    import cart_pkg::*;

    logic                  cs;
    logic [1:0]            page;
    logic [7:0]            nr_blocks;
    logic [7:0]            mask;
    logic                  bank_wr;
    logic [7:0]            bank_base;
    logic [7:0]            bank_q [NUM_IDS][1:KONAMI_BANKS-1];
    logic [MEM_ADDR_W-1:0] rom_addr;

    assign cs = (typ == MAPPER_KONAMI) && mreq && (addr[15] ^ addr[14]);

    // Page 0 starts at 4000, so bit 14 is inverted to number the pages from there
    assign page = {~addr[14], addr[13]};

    // Number of 8 KB banks in the ROM image
    assign nr_blocks = rom_size[20:13];
    assign mask      = block_mask(nr_blocks);

    // Writes anywhere in a switchable page set that page's bank
    assign bank_wr = cs && wr && req && (page != 2'd0);

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            // Banks start out mapped linearly
            for (int i = 0; i < NUM_IDS; i++) begin
                for (int j = 1; j < KONAMI_BANKS; j++) begin
                    bank_q[i][j] <= 8'(j);
                end
            end
        end else if (bank_wr) begin
            bank_q[block_id][page] <= data_in & mask;
        end
    end

    assign bank_base = (page == 2'd0) ? KONAMI_FIXED_BANK : bank_q[block_id][page];
    assign rom_addr  = MEM_ADDR_W'({bank_base, addr[12:0]});

    assign ram_cs   = cs && rd && (rom_addr < MEM_ADDR_W'(rom_size));
    // This board has no save RAM and never writes memory
    assign sram_cs  = 1'b0;
    assign rnw      = 1'b1;
    assign mem_addr = cs ? rom_addr : ADDR_IDLE;

    // The save RAM belongs to ASCII16 cartridges only
    assert property (@(posedge cpu_bus) disable iff (rst) !sram_cs)
        else $error("mapper_konami selected the save RAM");

    // A Konami descriptor with save RAM would leave that RAM unreachable
    assert property (@(posedge cpu_bus) disable iff (rst) cs |-> (sram_size == '0))
        else $error("Konami cartridge declares save RAM");

endmodule

// ==== source/cart_sram.sv ====
`timescale 1ns/1ps

module cart_sram (
    input  logic                            cpu_bus,
    input  logic                            rst,
    input  logic                            rd,
    input  logic                            a_ram_cs,
    input  logic                            a_sram_cs,
    input  logic                            a_rnw,
    input  logic [cart_pkg::MEM_ADDR_W-1:0] a_mem_addr,
    input  logic                            k_ram_cs,
    input  logic                            k_sram_cs,
    input  logic                            k_rnw,
    input  logic [cart_pkg::MEM_ADDR_W-1:0] k_mem_addr,
    input  logic [7:0]                      data_in,
    output logic                            rom_cs,
    output logic                            sram_cs,
    output logic                            rnw,
    output logic [cart_pkg::MEM_ADDR_W-1:0] mem_addr,
    output logic [7:0]                      rd_data,
    output logic                            rd_valid
);

    import cart_pkg::*;

    logic [7:0]             mem [SRAM_DEPTH];
    logic [SRAM_ADDR_W-1:0] mem_idx;
    logic                   mem_wr;
    logic                   rd_active;
    logic                   rd_start;

    // An idle mapper shows all ones and no selects, so OR and AND pick the active one
    assign rom_cs   = a_ram_cs | k_ram_cs;
    assign sram_cs  = a_sram_cs | k_sram_cs;
    assign rnw      = a_rnw & k_rnw;
    assign mem_addr = a_mem_addr & k_mem_addr;

    // The mapper already folded the offset to the save RAM size
    assign mem_idx = mem_addr[SRAM_ADDR_W-1:0];
    assign mem_wr  = sram_cs && !rnw;

    // rd stays high for the whole cycle, only its first clock starts a read
    assign rd_start = sram_cs && rd && !rd_active;

    always_ff @(posedge cpu_bus) begin
        if (mem_wr) begin
            mem[mem_idx] <= data_in;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (rd_start) begin
            rd_data <= mem[mem_idx];
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (rst) begin
            rd_active <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            rd_active <= sram_cs && rd;
            rd_valid  <= rd_start;
        end
    end

    // The descriptor type picks exactly one mapper, so the merge never overlaps
    assert property (@(posedge cpu_bus) disable iff (rst)
        !((a_ram_cs || a_sram_cs) && (k_ram_cs || k_sram_cs)))
        else $error("both mappers selected in the same cycle");

endmodule

// ==== source/cart_slot.sv ====
`timescale 1ns/1ps

module cart_slot (
    input  logic                             cpu_bus,
    input  logic                             rst,
    input  logic [15:0]                      addr,
    input  logic [7:0]                       data_in,
    input  logic                             mreq,
    input  logic                             req,
    input  logic                             rd,
    input  logic                             wr,
    input  cart_pkg::mapper_typ_t            typ,
    input  logic [cart_pkg::ID_W-1:0]        block_id,
    input  logic [cart_pkg::ROM_SIZE_W-1:0]  rom_size,
    input  logic [cart_pkg::SRAM_SIZE_W-1:0] sram_size,
    output logic                             rom_cs,
    output logic                             sram_cs,
    output logic                             rnw,
    output logic [cart_pkg::MEM_ADDR_W-1:0]  mem_addr,
    output logic [7:0]                       rd_data,
    output logic                             rd_valid
);

    import cart_pkg::*;

    // ASCII16 family request
    logic                  a_ram_cs;
    logic                  a_sram_cs;
    logic                  a_rnw;
    logic [MEM_ADDR_W-1:0] a_mem_addr;

    // Konami request
    logic                  k_ram_cs;
    logic                  k_sram_cs;
    logic                  k_rnw;
    logic [MEM_ADDR_W-1:0] k_mem_addr;

    // Both mappers watch every cycle and the descriptor type enables one of them
    mapper_ascii16 u_ascii16 (
        .cpu_bus   (cpu_bus),
        .rst       (rst),
        .addr      (addr),
        .data_in   (data_in),
        .mreq      (mreq),
        .req       (req),
        .rd        (rd),
        .wr        (wr),
        .typ       (typ),
        .block_id  (block_id),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .ram_cs    (a_ram_cs),
        .sram_cs   (a_sram_cs),
        .rnw       (a_rnw),
        .mem_addr  (a_mem_addr)
    );

    mapper_konami u_konami (
        .cpu_bus   (cpu_bus),
        .rst       (rst),
        .addr      (addr),
        .data_in   (data_in),
        .mreq      (mreq),
        .req       (req),
        .rd        (rd),
        .wr        (wr),
        .typ       (typ),
        .block_id  (block_id),
        .rom_size  (rom_size),
        .sram_size (sram_size),
        .ram_cs    (k_ram_cs),
        .sram_cs   (k_sram_cs),
        .rnw       (k_rnw),
        .mem_addr  (k_mem_addr)
    );

    // Merged request goes to the ROM port and the local save RAM
    cart_sram u_sram (
        .cpu_bus    (cpu_bus),
        .rst        (rst),
        .rd         (rd),
        .a_ram_cs   (a_ram_cs),
        .a_sram_cs  (a_sram_cs),
        .a_rnw      (a_rnw),
        .a_mem_addr (a_mem_addr),
        .k_ram_cs   (k_ram_cs),
        .k_sram_cs  (k_sram_cs),
        .k_rnw      (k_rnw),
        .k_mem_addr (k_mem_addr),
        .data_in    (data_in),
        .rom_cs     (rom_cs),
        .sram_cs    (sram_cs),
        .rnw        (rnw),
        .mem_addr   (mem_addr),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

// ==== testbench/tb_cart_slot.sv ====
`timescale 1ns/1ps

module tb_cart_slot;

    import cart_pkg::*;

    localparam logic [ROM_SIZE_W-1:0] ROM_128K = 25'h0020000;
    localparam logic [ROM_SIZE_W-1:0] ROM_256K = 25'h0040000;
    localparam logic [ROM_SIZE_W-1:0] ROM_512K = 25'h0080000;
    localparam int RD_TIMEOUT = 20;

    logic                   cpu_bus   = 1'b0;
    logic                   rst       = 1'b1;
    logic [15:0]            addr      = '0;
    logic [7:0]             data_in   = '0;
    logic                   mreq      = 1'b0;
    logic                   req       = 1'b0;
    logic                   rd        = 1'b0;
    logic                   wr        = 1'b0;
    mapper_typ_t            typ       = MAPPER_NONE;
    logic [ID_W-1:0]        block_id  = '0;
    logic [ROM_SIZE_W-1:0]  rom_size  = '0;
    logic [SRAM_SIZE_W-1:0] sram_size = '0;
    logic                   rom_cs;
    logic                   sram_cs;
    logic                   rnw;
    logic [MEM_ADDR_W-1:0]  mem_addr;
    logic [7:0]             rd_data;
    logic                   rd_valid;

    logic [31:0] rng_state = 32'd7491;
    string       test_name = "startup";
    // Expected ASCII16 family banks, indexed by cartridge id and page
    logic [7:0]  a16_exp [2][2];

    cart_slot UUT (.*);

    always #2 cpu_bus = ~cpu_bus;

    // Plain LCG, folded so that the low bits are less regular
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 16);
    endfunction

    // Bank values at or above the bank count wrap by the power of two mask
    function automatic logic [7:0] a16_bank(input logic [7:0] value, input logic [7:0] count);
        return (value < count) ? value : (value & (count - 8'd1));
    endfunction

    // ROM byte address inside a 16 KB bank
    function automatic logic [31:0] page16(input logic [7:0] bank, input logic [15:0] a);
        return {10'd0, bank, a[13:0]};
    endfunction

    // ROM byte address inside an 8 KB bank
    function automatic logic [31:0] page8(input logic [7:0] bank, input logic [15:0] a);
        return {11'd0, bank, a[12:0]};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error %s %s expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    // Descriptor only changes on an idle bus
    task automatic set_cart(input mapper_typ_t t, input logic [ID_W-1:0] id,
                            input logic [ROM_SIZE_W-1:0] rom,
                            input logic [SRAM_SIZE_W-1:0] sram);
        @(posedge cpu_bus);
        typ       <= t;
        block_id  <= id;
        rom_size  <= rom;
        sram_size <= sram;
    endtask

    // Opens a memory cycle and returns mid cycle, where the decode is settled
    task automatic start_cycle(input logic [15:0] a, input logic [7:0] d, input logic is_wr);
        @(posedge cpu_bus);
        addr    <= a;
        data_in <= d;
        mreq    <= 1'b1;
        req     <= 1'b1;
        rd      <= !is_wr;
        wr      <= is_wr;
        @(negedge cpu_bus);
    endtask

    // The edge here is the one that commits a bank or save RAM write
    task automatic end_cycle();
        @(posedge cpu_bus);
        mreq <= 1'b0;
        req  <= 1'b0;
        rd   <= 1'b0;
        wr   <= 1'b0;
    endtask

    task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
        start_cycle(a, d, 1'b1);
        end_cycle();
    endtask

    task automatic expect_rom(input logic [15:0] a, input logic [31:0] expected);
        start_cycle(a, 8'h00, 1'b0);
        check_value($sformatf("rom_cs at %h", a), 32'd1, 32'(rom_cs));
        check_value($sformatf("sram_cs at %h", a), 32'd0, 32'(sram_cs));
        check_value($sformatf("mem_addr at %h", a), expected, 32'(mem_addr));
        end_cycle();
    endtask

    // Outside 4000-BFFF nothing is selected and the address rests at all ones
    task automatic expect_idle(input logic [15:0] a);
        start_cycle(a, 8'h00, 1'b0);
        check_value($sformatf("rom_cs at %h", a), 32'd0, 32'(rom_cs));
        check_value($sformatf("sram_cs at %h", a), 32'd0, 32'(sram_cs));
        check_value($sformatf("mem_addr at %h", a), 32'(ADDR_IDLE), 32'(mem_addr));
        end_cycle();
    endtask

    task automatic reset_state();
        logic [31:0] r;
        test_name = "reset_state";
        for (int i = 0; i < 2; i++) begin
            a16_exp[i][0] = 8'h00;
            a16_exp[i][1] = 8'h00;
        end
        set_cart(MAPPER_ASCII16, '0, ROM_128K, '0);
        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            // Offset 4000 plus 15 random bits covers 4000-BFFF
            expect_rom(16'h4000 + {1'b0, r[14:0]}, {18'd0, r[13:0]});
            expect_idle({2'b00, r[29:16]});
            expect_idle({2'b11, r[29:16]});
        end
    endtask

    task automatic ascii16_switching();
        logic [31:0] r;
        logic [15:0] off;
        test_name = "ascii16_switching";
        for (int n = 0; n < 6; n++) begin
            // Alternate ids, then look at both so one id cannot leak into the other
            set_cart(MAPPER_ASCII16, ID_W'(n), ROM_128K, '0);
            r = next_rand();
            write_byte(16'h6000 | {5'd0, r[26:16]}, r[7:0]);
            write_byte(16'h7000 | {5'd0, r[26:16]}, r[15:8]);
            a16_exp[n % 2][0] = a16_bank(r[7:0], 8'd8);
            a16_exp[n % 2][1] = a16_bank(r[15:8], 8'd8);
            for (int k = 0; k < 2; k++) begin
                set_cart(MAPPER_ASCII16, ID_W'(k), ROM_128K, '0);
                r = next_rand();
                off = {2'b00, r[13:0]};
                expect_rom(16'h4000 | off, page16(a16_exp[k][0], off));
                expect_rom(16'h8000 | off, page16(a16_exp[k][1], off));
            end
        end
    endtask

    task automatic sram_access();
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  d;
        int          cycles;
        test_name = "sram_access";
        set_cart(MAPPER_ASCII16, '0, ROM_128K, 16'd8);
        write_byte(16'h7000, SRAM_BANK_CODE);
        for (int n = 0; n < 3; n++) begin
            r = next_rand();
            a = 16'h8000 | {2'b00, r[13:0]};
            d = r[23:16];
            start_cycle(a, d, 1'b1);
            check_value("write rnw", 32'd0, 32'(rnw));
            check_value("write sram_cs", 32'd1, 32'(sram_cs));
            // An 8 KB save RAM decodes 13 offset bits
            check_value("write mem_addr", {19'd0, a[12:0]}, 32'(mem_addr));
            end_cycle();
            start_cycle(a, 8'h00, 1'b0);
            check_value("read rnw", 32'd1, 32'(rnw));
            check_value("read rom_cs", 32'd0, 32'(rom_cs));
            check_value("read sram_cs", 32'd1, 32'(sram_cs));
            @(posedge cpu_bus);
            req <= 1'b0;
            cycles = 0;
            do begin
                @(negedge cpu_bus);
                cycles++;
            end while (!rd_valid && cycles < RD_TIMEOUT);
            if (!rd_valid) begin
                fail_run("save RAM read never raised rd_valid");
            end
            check_value("read latency", 32'd1, 32'(cycles));
            check_value("read data", 32'(d), 32'(rd_data));
            end_cycle();
            // The valid strobe lasts a single clock even though rd was still high
            @(negedge cpu_bus);
            check_value("rd_valid pulse", 32'd0, 32'(rd_valid));
            // The lower page keeps its ROM bank while the upper one shows save RAM
            expect_rom(a ^ 16'hC000, page16(a16_exp[0][0], a));
        end
        write_byte(16'h7000, 8'h03);
        a16_exp[0][1] = 8'h03;
        expect_rom(a, page16(8'h03, a));
    endtask

    task automatic variant_mapping();
        logic [31:0] r;
        logic [15:0] off;
        logic [7:0]  d;
        test_name = "rtype";
        set_cart(MAPPER_RTYPE, '0, ROM_512K, '0);
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            d = r[7:0];
            off = {2'b00, r[29:16]};
            write_byte(16'h7000 | {4'd0, r[19:8]}, d);
            // Data bit 4 picks the narrower mask
            a16_exp[0][1] = d & (d[4] ? 8'h17 : 8'h1F);
            // The ASCII16 lower window does nothing here
            write_byte(16'h6000, ~d);
            expect_rom(16'h4000 | off, page16(8'h0F, off));
            expect_rom(16'h8000 | off, page16(a16_exp[0][1], off));
        end
        test_name = "msxwrite";
        set_cart(MAPPER_MSXWRITE, '0, ROM_128K, 16'd8);
        r = next_rand();
        off = {2'b00, r[29:16]};
        write_byte(16'h6FFF, r[7:0]);
        // The SRAM code is an ordinary bank number on this board
        write_byte(16'h7FFF, SRAM_BANK_CODE);
        a16_exp[0][0] = a16_bank(r[7:0], 8'd8);
        a16_exp[0][1] = a16_bank(SRAM_BANK_CODE, 8'd8);
        expect_rom(16'h4000 | off, page16(a16_exp[0][0], off));
        expect_rom(16'h8000 | off, page16(a16_exp[0][1], off));
        test_name = "superswangi";
        set_cart(MAPPER_SUPERSWANGI, '0, ROM_128K, '0);
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            off = {2'b00, r[29:16]};
            write_byte(16'h8000, r[7:0]);
            a16_exp[0][1] = a16_bank(r[7:0] >> 1, 8'd8);
            expect_rom(16'h4000 | off, page16(a16_exp[0][0], off));
            expect_rom(16'h8000 | off, page16(a16_exp[0][1], off));
        end
    endtask

    task automatic konami_banks();
        logic [31:0] r;
        logic [7:0]  exp_bank [4];
        logic [7:0]  mask;
        test_name = "konami";
        // 256 KB holds 32 banks of 8 KB
        mask = 8'((ROM_256K >> 13) - 1);
        set_cart(MAPPER_KONAMI, '0, ROM_256K, '0);
        for (int p = 0; p < 4; p++) begin
            exp_bank[p] = 8'(p);
        end
        for (int n = 0; n < 4; n++) begin
            for (int p = 0; p < 4; p++) begin
                r = next_rand();
                expect_rom(16'h4000 + 16'(p * 'h2000) + {3'd0, r[12:0]},
                           page8(exp_bank[p], {3'd0, r[12:0]}));
            end
            r = next_rand();
            for (int p = 0; p < 4; p++) begin
                // Page 0 ignores the write and stays on bank 0
                write_byte(16'h4000 + 16'(p * 'h2000) + {3'd0, r[28:16]}, r[7:0] + 8'(p));
                if (p != 0) begin
                    exp_bank[p] = (r[7:0] + 8'(p)) & mask;
                end
            end
        end
    endtask

    initial begin
        repeat (2) @(posedge cpu_bus);
        rst <= 1'b0;
        reset_state();
        ascii16_switching();
        sram_access();
        variant_mapping();
        konami_banks();
        @(posedge cpu_bus);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
source/cart_pkg.sv
source/mapper_ascii16.sv
source/mapper_konami.sv
source/cart_sram.sv
source/cart_slot.sv
testbench/tb_cart_slot.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cart_slot
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
